/* verilog/afifo_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// Sizes are fixed here. DEPTH must stay a power of two and NFF at least 2
////////////////////////////////////////////////////////////////////////////
package afifo_pkg;

	// FIFO geometry
	localparam int LGFIFO = 3;
	localparam int DEPTH  = 1 << LGFIFO;
	localparam int WIDTH  = 16;

	// Synchronizer depth across the clock domains
	localparam int NFF    = 2;

	// One stored word
	typedef logic [WIDTH-1:0] data_t;

	// Memory index, no wrap bit
	typedef logic [LGFIFO-1:0] addr_t;

	// Pointer with wrap bit, binary or Gray form
	typedef logic [LGFIFO:0] ptr_t;

	// Pointer pair published by each pointer block
	typedef struct packed {
		ptr_t bin;
		ptr_t gray;
	} fifo_ptr_t;

	// Binary to reflected Gray code
	function automatic ptr_t bin2gray(input ptr_t bin);
		return bin ^ (bin >> 1);
	endfunction

endpackage

/* verilog/afifo_gray_sync.sv */
////////////////////////////////////////////////////////////////////////////
// Input must be a registered Gray count changing one bit per source edge
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module afifo_gray_sync import afifo_pkg::*; (
	// Destination clock and reset
	input  logic i_clk,
	input  logic i_reset_n,
	// Gray pointer from the source domain
	input  ptr_t i_gray,
	output ptr_t o_gray
);

	// Stage 0 may go metastable, later stages settle it
	ptr_t sync_q [NFF];

	// Shift chain, NFF destination edges from input to output
	always_ff @(posedge i_clk or negedge i_reset_n)
	begin
		if (!i_reset_n)
		begin
			sync_q <= '{default: '0};
		end
		else
		begin
			sync_q[0] <= i_gray;
			for (int i = 1; i < NFF; i++)
			begin
				sync_q[i] <= sync_q[i-1];
			end
		end
	end

	// Last stage only
	assign o_gray = sync_q[NFF-1];

endmodule

/* verilog/afifo_mem.sv */
////////////////////////////////////////////////////////////////////////////
// Storage array. Write and read ports run on unrelated clocks
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module afifo_mem import afifo_pkg::*; (
	// Write port
	input  logic  i_wclk,
	input  logic  i_wr_en,
	input  addr_t i_waddr,
	input  data_t i_wr_data,
	// Read port
	input  logic  gbl_clk,
	input  logic  i_rd_load,
	input  addr_t i_raddr,
	output data_t o_rd_data
);

	// DEPTH words of WIDTH bits
	data_t mem [DEPTH];

	////////////////////////////////////////////////////////////////////////////
	// Write port
	////////////////////////////////////////////////////////////////////////////

	// Strobe is already qualified by full
	always_ff @(posedge i_wclk)
	begin
		if (i_wr_en)
			mem[i_waddr] <= i_wr_data;
	end

	////////////////////////////////////////////////////////////////////////////
	// Read port
	////////////////////////////////////////////////////////////////////////////

	// Output register, the only read-side data stage
	// Address slot was written at least NFF read edges ago
	// so the word is stable when sampled
	always_ff @(posedge gbl_clk)
	begin
		if (i_rd_load)
			o_rd_data <= mem[i_raddr];
	end

endmodule

/* verilog/afifo_wr_ptr.sv */
////////////////////////////////////////////////////////////////////////////
// Write pointer and full flag. Full is pessimistic by the crossing delay
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module afifo_wr_ptr import afifo_pkg::*; (
	input  logic      i_wclk,
	input  logic      i_wr_reset_n,
	input  logic      i_wr,
	// Read Gray pointer, already synchronized
	input  ptr_t      i_wr_rgray,
	output fifo_ptr_t o_wptr,
	output logic      o_wr_en,
	output logic      o_wr_full
);

	// Next binary value, one past the current slot
	ptr_t next_bin;

	// Write pointer with top two bits flipped
	ptr_t full_gray;

	assign next_bin = o_wptr.bin + 1'b1;

	////////////////////////////////////////////////////////////////////////////
	// Full detection
	////////////////////////////////////////////////////////////////////////////

	// Full when the writer is exactly one lap ahead
	// In Gray code a lap flips the top two bits
	assign full_gray = {~o_wptr.gray[LGFIFO:LGFIFO-1], o_wptr.gray[LGFIFO-2:0]};

	// Only registers feed this compare
	assign o_wr_full = (i_wr_rgray == full_gray);

	// Accepted write, also the memory write strobe
	assign o_wr_en = i_wr && !o_wr_full;

	////////////////////////////////////////////////////////////////////////////
	// Pointer registers
	////////////////////////////////////////////////////////////////////////////

	// Binary and Gray copies move on the same accepting edge
	// Gray is registered so the crossing sees a clean one-bit step
	always_ff @(posedge i_wclk or negedge i_wr_reset_n)
	begin
		if (!i_wr_reset_n)
		begin
			o_wptr.bin  <= '0;
			o_wptr.gray <= '0;
		end
		else if (o_wr_en)
		begin
			o_wptr.bin  <= next_bin;
			o_wptr.gray <= bin2gray(next_bin);
		end
	end

endmodule

/* verilog/afifo_rd_ptr.sv */
////////////////////////////////////////////////////////////////////////////
// Read pointer, empty flags and output-stage refill decision
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module afifo_rd_ptr import afifo_pkg::*; (
	input  logic      gbl_clk,
	input  logic      i_rd_reset_n,
	input  logic      i_rd,
	// Write Gray pointer, already synchronized
	input  ptr_t      i_rd_wgray,
	output fifo_ptr_t o_rptr,
	output logic      o_rd_load,
	output logic      o_rd_empty
);

	// Memory has nothing beyond the word at the output
	logic mem_empty;

	// Next binary value
	ptr_t next_bin;

	assign next_bin = o_rptr.bin + 1'b1;

	////////////////////////////////////////////////////////////////////////////
	// Internal empty and load decision
	////////////////////////////////////////////////////////////////////////////

	// Equal Gray pointers, nothing left to fetch
	assign mem_empty = (i_rd_wgray == o_rptr.gray);

	// Refill when the output stage is vacant or being consumed
	// A held word stays put while i_rd is low
	assign o_rd_load = o_rd_empty || i_rd;

	////////////////////////////////////////////////////////////////////////////
	// Registers
	////////////////////////////////////////////////////////////////////////////

	// Output-stage valid, inverted
	always_ff @(posedge gbl_clk or negedge i_rd_reset_n)
	begin
		if (!i_rd_reset_n)
			o_rd_empty <= 1'b1;
		else if (o_rd_load)
			o_rd_empty <= mem_empty;
	end

	// Pointer steps only when a real word was fetched
	always_ff @(posedge gbl_clk or negedge i_rd_reset_n)
	begin
		if (!i_rd_reset_n)
		begin
			o_rptr.bin  <= '0;
			o_rptr.gray <= '0;
		end
		else if (o_rd_load && !mem_empty)
		begin
			o_rptr.bin  <= next_bin;
			o_rptr.gray <= bin2gray(next_bin);
		end
	end

endmodule

/* verilog/afifo_top.sv */
////////////////////////////////////////////////////////////////////////////
// Dual-clock FIFO. Both resets are expected to be asserted together
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module afifo_top import afifo_pkg::*; (
	// Write domain
	input  logic  i_wclk,
	input  logic  i_wr_reset_n,
	input  logic  i_wr,
	input  data_t i_wr_data,
	output logic  o_wr_full,
	// Read domain
	input  logic  gbl_clk,
	input  logic  i_rd_reset_n,
	input  logic  i_rd,
	output data_t o_rd_data,
	output logic  o_rd_empty
);

	// Pointer pairs of each side
	fifo_ptr_t wptr;
	fifo_ptr_t rptr;

	// Gray pointers after the crossing
	ptr_t rd_wgray;
	ptr_t wr_rgray;

	// Memory strobes
	logic wr_en;
	logic rd_load;

	////////////////////////////////////////////////////////////////////////////
	// Write domain
	////////////////////////////////////////////////////////////////////////////

	afifo_wr_ptr u_wr_ptr (
		.i_wclk       (i_wclk),
		.i_wr_reset_n (i_wr_reset_n),
		.i_wr         (i_wr),
		.i_wr_rgray   (wr_rgray),
		.o_wptr       (wptr),
		.o_wr_en      (wr_en),
		.o_wr_full    (o_wr_full)
	);

	// Read Gray pointer into the write domain
	afifo_gray_sync u_rgray_sync (
		.i_clk     (i_wclk),
		.i_reset_n (i_wr_reset_n),
		.i_gray    (rptr.gray),
		.o_gray    (wr_rgray)
	);

	////////////////////////////////////////////////////////////////////////////
	// Read domain
	////////////////////////////////////////////////////////////////////////////

	afifo_rd_ptr u_rd_ptr (
		.gbl_clk      (gbl_clk),
		.i_rd_reset_n (i_rd_reset_n),
		.i_rd         (i_rd),
		.i_rd_wgray   (rd_wgray),
		.o_rptr       (rptr),
		.o_rd_load    (rd_load),
		.o_rd_empty   (o_rd_empty)
	);

	// Write Gray pointer into the read domain
	afifo_gray_sync u_wgray_sync (
		.i_clk     (gbl_clk),
		.i_reset_n (i_rd_reset_n),
		.i_gray    (wptr.gray),
		.o_gray    (rd_wgray)
	);

	// Storage, addressed by the low bits of the binary pointers
	afifo_mem u_mem (
		.i_wclk    (i_wclk),
		.i_wr_en   (wr_en),
		.i_waddr   (wptr.bin[LGFIFO-1:0]),
		.i_wr_data (i_wr_data),
		.gbl_clk   (gbl_clk),
		.i_rd_load (rd_load),
		.i_raddr   (rptr.bin[LGFIFO-1:0]),
		.o_rd_data (o_rd_data)
	);

endmodule

/* bench/afifo_checker.sv */
////////////////////////////////////////////////////////////////////////////
// Model holds up to 1024 outstanding words. Counts clear with the DUT resets
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module afifo_checker import afifo_pkg::*; (
	input  logic  i_wclk,
	input  logic  i_wr_reset_n,
	input  logic  i_wr,
	input  data_t i_wr_data,
	input  logic  i_wr_full,
	input  logic  gbl_clk,
	input  logic  i_rd_reset_n,
	input  logic  i_rd,
	input  data_t i_rd_data,
	input  logic  i_rd_empty,
	output int    o_err_count,
	output int    o_queue_len
);

	// Circular model queue, each count owned by one clock
	data_t model_q [1024];
	int    wr_count;
	int    rd_count;

	// Output word that must not move at the next read edge
	logic  held;
	data_t held_data;

	assign o_queue_len = wr_count - rd_count;

	// Accepted writes enter the model
	always @(posedge i_wclk or negedge i_wr_reset_n)
	begin
		if (!i_wr_reset_n)
			wr_count <= 0;
		else if (i_wr && !i_wr_full)
		begin
			model_q[wr_count[9:0]] <= i_wr_data;
			wr_count <= wr_count + 1;
		end
	end

	// Accepted reads pop the model and compare
	always @(posedge gbl_clk or negedge i_rd_reset_n)
	begin
		int errs;
		errs = 0;
		if (!i_rd_reset_n)
		begin
			rd_count <= 0;
			held <= 1'b0;
			o_err_count <= 0;
		end
		else
		begin
			// Held word, flag and data frozen
			if (held && (i_rd_empty || i_rd_data !== held_data))
			begin
				$display("error at %0t ns: o_rd_data expected %h got %h, o_rd_empty %b",
					$time, held_data, i_rd_data, i_rd_empty);
				errs++;
			end
			if (i_rd && !i_rd_empty && rd_count == wr_count)
			begin
				$display("error at %0t ns: a word was read but nothing was written", $time);
				errs++;
			end
			else if (i_rd && !i_rd_empty)
			begin
				if (i_rd_data !== model_q[rd_count[9:0]])
				begin
					$display("error at %0t ns: o_rd_data expected %h got %h",
						$time, model_q[rd_count[9:0]], i_rd_data);
					errs++;
				end
				rd_count <= rd_count + 1;
			end
			held <= !i_rd_empty && !i_rd;
			held_data <= i_rd_data;
			o_err_count <= o_err_count + errs;
		end
	end

endmodule

/* bench/afifo_tb.sv */
////////////////////////////////////////////////////////////////////////////
// Fixed LCG seed. Capacity is DEPTH plus the word in the output register
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module afifo_tb import afifo_pkg::*; ();

	logic  gbl_clk, i_wclk, i_rd_reset_n, i_wr_reset_n, i_wr, i_rd, o_wr_full, o_rd_empty;
	data_t i_wr_data, o_rd_data;
	int    chk_errors, queue_len;
	int    tb_errors = 0;
	int    mark = 0;
	int    passed = 0;
	int    unsigned wr_seed = 22003;
	int    unsigned rd_seed;

	// Read clock 8 ns, write clock 10 ns
	always #4 gbl_clk = ~gbl_clk;
	always #5 i_wclk = ~i_wclk;

	afifo_top dut0 (.*);

	afifo_checker chk0 (
		.i_wr_full   (o_wr_full),
		.i_rd_data   (o_rd_data),
		.i_rd_empty  (o_rd_empty),
		.o_err_count (chk_errors),
		.o_queue_len (queue_len),
		.*
	);

	function automatic int unsigned lcg_next(input int unsigned state);
		return (state * 32'd1103515245 + 32'd12345) & 32'h7fff_ffff;
	endfunction

	task automatic check_val(input string name, input int got, input int exp);
		if (got != exp)
		begin
			$display("error at %0t ns: %s expected %0d got %0d", $time, name, exp, got);
			tb_errors++;
		end
	endtask

	task automatic report_timeout(input string what);
		$display("timeout at %0t ns while waiting for %s", $time, what);
		tb_errors++;
	endtask

	// Leaves on the first write edge that sees full low
	task automatic wait_full_clear();
		int t;
		t = 0;
		do
		begin
			@(posedge i_wclk);
			t++;
		end
		while (o_wr_full && t < 200);
		if (o_wr_full)
			report_timeout("o_wr_full to fall");
	endtask

	// Held until that accepting edge
	task automatic write_word(input data_t d);
		@(posedge i_wclk);
		i_wr <= 1'b1;
		i_wr_data <= d;
		wait_full_clear();
		i_wr <= 1'b0;
	endtask

	// Waits for a word, then one i_rd edge
	task automatic read_word();
		int t;
		t = 0;
		do
		begin
			@(posedge gbl_clk);
			t++;
		end
		while (o_rd_empty && t < 200);
		if (o_rd_empty)
			report_timeout("o_rd_empty to fall");
		i_rd <= !o_rd_empty;
		@(posedge gbl_clk);
		i_rd <= 1'b0;
	endtask

	// Empty for quiet_edges edges in a row, covers words still crossing
	task automatic wait_empty_set(input int quiet_edges);
		int t;
		int run;
		t = 0;
		run = 0;
		while (run < quiet_edges && t < 200)
		begin
			@(posedge gbl_clk);
			t++;
			run = o_rd_empty ? run + 1 : 0;
		end
		if (run < quiet_edges)
			report_timeout("o_rd_empty to rise");
	endtask

	task automatic finish_test(input int num, input string name);
		repeat (3) @(posedge gbl_clk);
		passed += (tb_errors + chk_errors == mark);
		$display("test %0d %s: %s", num, name, (tb_errors + chk_errors == mark) ? "pass" : "fail");
		mark = tb_errors + chk_errors;
	endtask

	initial
	begin
		gbl_clk = 1'b0;
		i_wclk = 1'b0;
		i_rd_reset_n = 1'b0;
		i_wr_reset_n = 1'b0;
		i_wr = 1'b0;
		i_rd = 1'b0;
		i_wr_data = '0;
		rd_seed = lcg_next(wr_seed);
		repeat (2) @(posedge gbl_clk);
		i_rd_reset_n <= 1'b1;
		i_wr_reset_n <= 1'b1;

		@(negedge gbl_clk);
		check_val("o_rd_empty", o_rd_empty, 1);
		check_val("o_wr_full", o_wr_full, 0);
		finish_test(1, "reset flags");

		// Reader idle, full only on the last slot
		for (int i = 1; i <= DEPTH + 1; i++)
		begin
			wr_seed = lcg_next(wr_seed);
			write_word(wr_seed[30:15]);
			@(negedge i_wclk);
			check_val("o_wr_full", o_wr_full, i == DEPTH + 1);
		end
		// Refused writes, drain shows nothing overwritten
		@(posedge i_wclk);
		i_wr <= 1'b1;
		i_wr_data <= wr_seed[15:0];
		repeat (4) @(posedge i_wclk);
		check_val("o_wr_full", o_wr_full, 1);
		i_wr <= 1'b0;
		check_val("model queue length", queue_len, DEPTH + 1);
		finish_test(2, "fill until full");

		read_word();
		wait_full_clear();
		for (int i = 1; i <= DEPTH; i++)
			read_word();
		wait_empty_set(1);
		check_val("model queue length", queue_len, 0);
		finish_test(3, "drain after full");

		@(posedge gbl_clk);
		i_rd <= 1'b1;
		repeat (6) @(posedge gbl_clk);
		check_val("o_rd_empty", o_rd_empty, 1);
		i_rd <= 1'b0;
		wr_seed = lcg_next(wr_seed);
		write_word(wr_seed[30:15]);
		read_word();
		wait_empty_set(1);
		check_val("model queue length", queue_len, 0);
		finish_test(4, "read while empty");

		// Write 5 of 8 edges, read 4 of 8, both flags get exercised
		fork
			begin
				repeat (300)
				begin
					@(posedge i_wclk);
					wr_seed = lcg_next(wr_seed);
					i_wr <= (wr_seed[18:16] < 3'd5);
					i_wr_data <= wr_seed[30:15];
				end
				@(posedge i_wclk);
				i_wr <= 1'b0;
			end
			repeat (300)
			begin
				@(posedge gbl_clk);
				rd_seed = lcg_next(rd_seed);
				i_rd <= (rd_seed[18:16] < 3'd4);
			end
		join
		@(posedge gbl_clk);
		i_rd <= 1'b1;
		wait_empty_set(10);
		i_rd <= 1'b0;
		@(posedge gbl_clk);
		check_val("model queue length", queue_len, 0);
		finish_test(5, "mixed random traffic");

		$display("summary: %0d passed, %0d failed, %0d errors", passed, 5 - passed,
			tb_errors + chk_errors);
		if (passed == 5)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

/* afifo.f */
verilog/afifo_pkg.sv
verilog/afifo_gray_sync.sv
verilog/afifo_mem.sv
verilog/afifo_wr_ptr.sv
verilog/afifo_rd_ptr.sv
verilog/afifo_top.sv
bench/afifo_checker.sv
bench/afifo_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the afifo testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f afifo.f --top-module afifo_tb \
	--Mdir obj_dir -o afifo_sim
./obj_dir/afifo_sim > sim.log 2>&1
cat sim.log

if grep -q "all tests passed" sim.log
then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
